//--- hdl/mips_pkg.sv
package mips_pkg;

    // datapath widths
    localparam int NB_DATA     = 32;
    localparam int NB_ADDR     = 5;
    localparam int NB_OPCODE   = 6;
    localparam int NB_IMM      = 16;
    localparam int N_REGS      = 32;

    // data memory, word index taken from address bits 7:2
    localparam int DMEM_WORDS  = 64;
    localparam int NB_DMEM_IDX = $clog2(DMEM_WORDS);

    // alu operation codes
    localparam int NB_ALU_OP = 3;
    localparam logic [NB_ALU_OP-1:0] ALU_ADD = 3'd0;
    localparam logic [NB_ALU_OP-1:0] ALU_SUB = 3'd1;
    localparam logic [NB_ALU_OP-1:0] ALU_AND = 3'd2;
    localparam logic [NB_ALU_OP-1:0] ALU_OR  = 3'd3;
    localparam logic [NB_ALU_OP-1:0] ALU_XOR = 3'd4;
    localparam logic [NB_ALU_OP-1:0] ALU_SLT = 3'd5;

    // primary opcodes
    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
    localparam logic [NB_OPCODE-1:0] OP_ADDIU = 6'h09;
    localparam logic [NB_OPCODE-1:0] OP_ANDI  = 6'h0c;
    localparam logic [NB_OPCODE-1:0] OP_ORI   = 6'h0d;
    localparam logic [NB_OPCODE-1:0] OP_LW    = 6'h23;
    localparam logic [NB_OPCODE-1:0] OP_SW    = 6'h2b;

    // funct field of r-type
    localparam logic [NB_OPCODE-1:0] FN_ADDU = 6'h21;
    localparam logic [NB_OPCODE-1:0] FN_SUBU = 6'h23;
    localparam logic [NB_OPCODE-1:0] FN_AND  = 6'h24;
    localparam logic [NB_OPCODE-1:0] FN_OR   = 6'h25;
    localparam logic [NB_OPCODE-1:0] FN_XOR  = 6'h26;
    localparam logic [NB_OPCODE-1:0] FN_SLT  = 6'h2a;

    // one instruction word, seen as r-format or i-format
    typedef union packed {
        struct packed {
            logic [NB_OPCODE-1:0] opcode;
            logic [NB_ADDR-1:0]   rs;
            logic [NB_ADDR-1:0]   rt;
            logic [NB_ADDR-1:0]   rd;
            logic [NB_ADDR-1:0]   shamt;
            logic [NB_OPCODE-1:0] funct;
        } r_fmt;
        struct packed {
            logic [NB_OPCODE-1:0] opcode;
            logic [NB_ADDR-1:0]   rs;
            logic [NB_ADDR-1:0]   rt;
            logic [NB_IMM-1:0]    imm;
        } i_fmt;
    } instr_t;

endpackage

//--- hdl/mips_stage_if.sv
`timescale 1ns/1ps

// decode to execute
interface id_ex_if;
    import mips_pkg::*;

    logic                 valid;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 alu_src_imm;
    logic [NB_ALU_OP-1:0] alu_op;
    logic [NB_DATA-1:0]   rs_data;
    logic [NB_DATA-1:0]   rt_data;
    logic [NB_DATA-1:0]   imm_ext;
    logic [NB_ADDR-1:0]   dest;

    modport decode (output valid, reg_write, mem_read, mem_write, alu_src_imm,
                    alu_op, rs_data, rt_data, imm_ext, dest);
    modport execute (input valid, reg_write, mem_read, mem_write, alu_src_imm,
                     alu_op, rs_data, rt_data, imm_ext, dest);
endinterface

// execute to memory / write-back
interface ex_res_if;
    import mips_pkg::*;

    logic               valid;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic [NB_DATA-1:0] alu_result;
    logic [NB_DATA-1:0] store_data;
    logic [NB_ADDR-1:0] dest;

    modport execute (output valid, reg_write, mem_read, mem_write, alu_result,
                     store_data, dest);
    modport result (input valid, reg_write, mem_read, mem_write, alu_result,
                    store_data, dest);
endinterface

// write-back path into the register file
interface wb_if;
    import mips_pkg::*;

    logic               valid;
    logic [NB_ADDR-1:0] dest;
    logic [NB_DATA-1:0] data;

    modport result (output valid, dest, data);
    modport decode (input valid, dest, data);
endinterface

//--- hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic [mips_pkg::NB_ADDR-1:0] i_rs_addr,
    input  logic [mips_pkg::NB_ADDR-1:0] i_rt_addr,
    input  logic                        i_wr_en,
    input  logic [mips_pkg::NB_ADDR-1:0] i_wr_addr,
    input  logic [mips_pkg::NB_DATA-1:0] i_wr_data,
    output logic [mips_pkg::NB_DATA-1:0] o_rs_data,
    output logic [mips_pkg::NB_DATA-1:0] o_rt_data
);
    import mips_pkg::*;

    logic [NB_DATA-1:0] regs [N_REGS];

    // r0 stays zero, the pending write is visible the same cycle
    function automatic logic [NB_DATA-1:0] read_port(input logic [NB_ADDR-1:0] addr);
        if (addr == '0)
            return '0;
        else if (i_wr_en && (i_wr_addr == addr))
            return i_wr_data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    always_comb begin
        o_rs_data = read_port(i_rs_addr);
        o_rt_data = read_port(i_rt_addr);
    end

endmodule

//--- hdl/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_instr_valid,
    input  mips_pkg::instr_t i_instr,
    wb_if.decode             i_wb,
    id_ex_if.decode          o_id_ex
);
    import mips_pkg::*;

    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 alu_src_imm;
    logic                 dest_is_rt;
    logic                 imm_signed;
    logic [NB_ALU_OP-1:0] alu_op;
    logic [NB_ADDR-1:0]   dest;
    logic                 write_ok;
    logic [NB_DATA-1:0]   imm_ext;
    logic [NB_DATA-1:0]   rs_data;
    logic [NB_DATA-1:0]   rt_data;

    // control from opcode and funct, unknown codes fall through as no-ops
    always_comb begin
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b1;
        dest_is_rt  = 1'b1;
        imm_signed  = 1'b1;
        alu_op      = ALU_ADD;
        case (i_instr.r_fmt.opcode)
            OP_RTYPE: begin
                alu_src_imm = 1'b0;
                dest_is_rt  = 1'b0;
                reg_write   = 1'b1;
                case (i_instr.r_fmt.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: reg_write = 1'b1;
            OP_ANDI: begin
                reg_write  = 1'b1;
                imm_signed = 1'b0;
                alu_op     = ALU_AND;
            end
            OP_ORI: begin
                reg_write  = 1'b1;
                imm_signed = 1'b0;
                alu_op     = ALU_OR;
            end
            OP_LW: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SW:   mem_write = 1'b1;
            default: ;
        endcase
    end

    assign dest     = dest_is_rt ? i_instr.i_fmt.rt : i_instr.r_fmt.rd;
    // writes to r0 are dropped here so nothing downstream sees them
    assign write_ok = reg_write && (dest != '0);
    assign imm_ext  = {{(NB_DATA-NB_IMM){imm_signed & i_instr.i_fmt.imm[NB_IMM-1]}},
                       i_instr.i_fmt.imm};

    register_file u_register_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs_addr (i_instr.i_fmt.rs),
        .i_rt_addr (i_instr.i_fmt.rt),
        .i_wr_en   (i_wb.valid),
        .i_wr_addr (i_wb.dest),
        .i_wr_data (i_wb.data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex.valid     <= 1'b0;
            o_id_ex.reg_write <= 1'b0;
            o_id_ex.mem_read  <= 1'b0;
            o_id_ex.mem_write <= 1'b0;
        end else begin
            o_id_ex.valid     <= i_instr_valid && (write_ok || mem_write);
            o_id_ex.reg_write <= i_instr_valid && write_ok;
            o_id_ex.mem_read  <= i_instr_valid && mem_read;
            o_id_ex.mem_write <= i_instr_valid && mem_write;
        end
    end

    // operands and immediate
    always_ff @(posedge i_clk) begin
        o_id_ex.alu_src_imm <= alu_src_imm;
        o_id_ex.alu_op      <= alu_op;
        o_id_ex.rs_data     <= rs_data;
        o_id_ex.rt_data     <= rt_data;
        o_id_ex.imm_ext     <= imm_ext;
        o_id_ex.dest        <= dest;
    end

endmodule

//--- hdl/instruction_execute.sv
`timescale 1ns/1ps

module instruction_execute (
    input  logic      i_clk,
    input  logic      i_rst_n,
    id_ex_if.execute  i_id_ex,
    ex_res_if.execute o_ex_res
);
    import mips_pkg::*;

    logic [NB_DATA-1:0] operand_a;
    logic [NB_DATA-1:0] operand_b;
    logic [NB_DATA-1:0] alu_result;
    logic               signed_lt;

    assign operand_a = i_id_ex.rs_data;

    // second operand is rt or the extended immediate
    assign operand_b = i_id_ex.alu_src_imm ? i_id_ex.imm_ext : i_id_ex.rt_data;

    // slt compares as two's complement
    assign signed_lt = $signed(operand_a) < $signed(operand_b);

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_result = operand_a + operand_b;
            ALU_SUB: alu_result = operand_a - operand_b;
            ALU_AND: alu_result = operand_a & operand_b;
            ALU_OR:  alu_result = operand_a | operand_b;
            ALU_XOR: alu_result = operand_a ^ operand_b;
            ALU_SLT: alu_result = {{(NB_DATA-1){1'b0}}, signed_lt};
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_res.valid     <= 1'b0;
            o_ex_res.reg_write <= 1'b0;
            o_ex_res.mem_read  <= 1'b0;
            o_ex_res.mem_write <= 1'b0;
        end else begin
            o_ex_res.valid     <= i_id_ex.valid;
            o_ex_res.reg_write <= i_id_ex.valid && i_id_ex.reg_write;
            o_ex_res.mem_read  <= i_id_ex.valid && i_id_ex.mem_read;
            o_ex_res.mem_write <= i_id_ex.valid && i_id_ex.mem_write;
        end
    end

    // result, store data and destination
    always_ff @(posedge i_clk) begin
        o_ex_res.alu_result <= alu_result;
        o_ex_res.store_data <= i_id_ex.rt_data;
        o_ex_res.dest       <= i_id_ex.dest;
    end

endmodule

//--- hdl/memory_writeback.sv
`timescale 1ns/1ps

module memory_writeback (
    input  logic     i_clk,
    input  logic     i_rst_n,
    ex_res_if.result i_ex_res,
    wb_if.result     o_wb
);
    import mips_pkg::*;

    logic [NB_DATA-1:0]     dmem [DMEM_WORDS];
    logic [NB_DMEM_IDX-1:0] word_idx;
    logic [NB_DATA-1:0]     load_data;

    // word addressed, byte offset ignored
    assign word_idx  = i_ex_res.alu_result[NB_DMEM_IDX+1:2];
    assign load_data = dmem[word_idx];

    // store lands at the same edge as the write-back register
    always_ff @(posedge i_clk) begin
        if (i_ex_res.valid && i_ex_res.mem_write) begin
            dmem[word_idx] <= i_ex_res.store_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= i_ex_res.valid && i_ex_res.reg_write;
        end
    end

    // load data or alu result
    always_ff @(posedge i_clk) begin
        o_wb.dest <= i_ex_res.dest;
        o_wb.data <= i_ex_res.mem_read ? load_data : i_ex_res.alu_result;
    end

endmodule

//--- hdl/mips_pipeline_top.sv
`timescale 1ns/1ps

module mips_pipeline_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_instr_valid,
    input  logic [mips_pkg::NB_DATA-1:0] i_instr,
    output logic                        o_wb_valid,
    output logic [mips_pkg::NB_ADDR-1:0] o_wb_reg,
    output logic [mips_pkg::NB_DATA-1:0] o_wb_data
);

    id_ex_if  id_ex_bus ();
    ex_res_if ex_res_bus ();
    wb_if     wb_bus ();

    instruction_decode u_instruction_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_wb          (wb_bus.decode),
        .o_id_ex       (id_ex_bus.decode)
    );

    instruction_execute u_instruction_execute (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_id_ex  (id_ex_bus.execute),
        .o_ex_res (ex_res_bus.execute)
    );

    memory_writeback u_memory_writeback (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ex_res (ex_res_bus.result),
        .o_wb     (wb_bus.result)
    );

    // write-back is visible outside as well
    assign o_wb_valid = wb_bus.valid;
    assign o_wb_reg   = wb_bus.dest;
    assign o_wb_data  = wb_bus.data;

endmodule

//--- tb/mips_pipeline_checker.sv
`timescale 1ns/1ps

module mips_pipeline_checker (
    input logic                         i_clk,
    input logic                         i_rst_n,
    input logic                         i_instr_valid,
    input logic                         i_wb_valid,
    input logic [mips_pkg::NB_ADDR-1:0] i_wb_reg
);

    // nothing leaves the pipeline while reset is held
    assert property (@(posedge i_clk) !i_rst_n |-> !i_wb_valid)
        else $error("write-back valid seen during reset");

    // r0 is never a write-back target
    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_wb_valid |-> (i_wb_reg != '0))
        else $error("write-back to r0");

    // empty issue slot gives an empty write-back slot three cycles on
    assert property (@(posedge i_clk) disable iff (!i_rst_n) !i_instr_valid |-> ##3 !i_wb_valid)
        else $error("write-back without an issued instruction");

endmodule

bind mips_pipeline_top mips_pipeline_checker checker_i (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_instr_valid (i_instr_valid),
    .i_wb_valid    (o_wb_valid),
    .i_wb_reg      (o_wb_reg)
);

//--- tb/mips_pipeline_tb.sv
`timescale 1ns/1ps

module mips_pipeline_tb;
    import mips_pkg::*;

    // issue slots of all six tests in run order
    localparam int N_SLOTS    = 10 + 10 + 16 + 14 + 9 + 8;
    localparam int TIMEOUT_NS = N_SLOTS * 10 * 2 + 4 * 10;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;

    // expected write-back of the last three slots with the oldest at index 2
    logic        exp_valid [3];
    logic [4:0]  exp_reg [3];
    logic [31:0] exp_data [3];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [64];
    int          check_count;
    int          error_count;
    int          test_base;

    mips_pipeline_top dut_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .o_wb_valid    (wb_valid),
        .o_wb_reg      (wb_reg),
        .o_wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, tests did not complete", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rt,
                                             input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] rand_imm(input logic negative);
        return negative ? (16'h8000 | 16'($urandom)) : (16'h7fff & 16'($urandom));
    endfunction

    // architectural effect of one instruction on the model state
    task automatic model_issue(input logic [31:0] word, output logic v,
                               output logic [4:0] dst, output logic [31:0] res);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        a   = ref_regs[word[25:21]];
        b   = ref_regs[word[20:16]];
        sx  = {{16{word[15]}}, word[15:0]};
        zx  = {16'h0000, word[15:0]};
        v   = 1'b1;
        dst = word[20:16];
        res = '0;
        case (word[31:26])
            OP_RTYPE: begin
                dst = word[15:11];
                case (word[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: v = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + sx;
            OP_ANDI:  res = a & zx;
            OP_ORI:   res = a | zx;
            OP_LW:    res = ref_mem[(a + sx) >> 2 & 32'h3f];
            OP_SW: begin
                ref_mem[(a + sx) >> 2 & 32'h3f] = b;
                v = 1'b0;
            end
            default:  v = 1'b0;
        endcase
        if (dst == 5'd0)
            v = 1'b0;
        if (v)
            ref_regs[dst] = res;
    endtask

    // check the write-back due in this slot and drive the next input
    task automatic step(input logic valid, input logic [31:0] word);
        logic        v;
        logic [4:0]  dst;
        logic [31:0] res;
        @(negedge clk);
        check_value("o_wb_valid", 32'(wb_valid), 32'(exp_valid[2]));
        if (exp_valid[2]) begin
            check_value("o_wb_reg", 32'(wb_reg), 32'(exp_reg[2]));
            check_value("o_wb_data", wb_data, exp_data[2]);
        end
        v   = 1'b0;
        dst = '0;
        res = '0;
        if (valid)
            model_issue(word, v, dst, res);
        for (int i = 2; i > 0; i--) begin
            exp_valid[i] = exp_valid[i-1];
            exp_reg[i]   = exp_reg[i-1];
            exp_data[i]  = exp_data[i-1];
        end
        exp_valid[0] = v;
        exp_reg[0]   = dst;
        exp_data[0]  = res;
        instr_valid  = valid;
        instr        = valid ? word : '0;
    endtask

    task automatic issue(input logic [31:0] word);
        step(1'b1, word);
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, '0);
    endtask

    task automatic report_test(input string name);
        idle(3);
        $display("test %s finished with %0d errors", name, error_count - test_base);
        test_base = error_count;
    endtask

    task automatic reset_sequence();
        rst_n = 1'b0;
        idle(4);
        rst_n = 1'b1;
        idle(2);
        issue(encode_r(FN_OR, 5'd1, 5'd0, 5'd0));
        report_test("reset");
    endtask

    task automatic immediate_ops();
        issue(encode_i(OP_ADDIU, 5'd1, 5'd0, rand_imm(1'b1)));
        issue(encode_i(OP_ADDIU, 5'd2, 5'd0, rand_imm(1'b0)));
        issue(encode_i(OP_ADDIU, 5'd3, 5'd0, rand_imm(1'b1)));
        issue(encode_i(OP_ADDIU, 5'd4, 5'd0, rand_imm(1'b0)));
        // bit 15 set so zero extension shows
        issue(encode_i(OP_ANDI, 5'd5, 5'd1, rand_imm(1'b1)));
        issue(encode_i(OP_ORI, 5'd6, 5'd2, rand_imm(1'b1)));
        issue(encode_i(OP_ORI, 5'd7, 5'd0, rand_imm(1'b1)));
        report_test("immediates");
    endtask

    task automatic register_alu_ops();
        issue(encode_i(OP_ADDIU, 5'd8, 5'd0, rand_imm(1'b1)));
        issue(encode_i(OP_ADDIU, 5'd9, 5'd0, rand_imm(1'b0)));
        issue(encode_i(OP_ADDIU, 5'd10, 5'd0, rand_imm(1'($urandom))));
        issue(encode_i(OP_ADDIU, 5'd11, 5'd0, rand_imm(1'($urandom))));
        idle(2);
        issue(encode_r(FN_ADDU, 5'd12, 5'd8, 5'd9));
        issue(encode_r(FN_SUBU, 5'd13, 5'd10, 5'd11));
        issue(encode_r(FN_AND, 5'd14, 5'd8, 5'd10));
        issue(encode_r(FN_OR, 5'd15, 5'd9, 5'd11));
        issue(encode_r(FN_XOR, 5'd16, 5'd10, 5'd8));
        // r8 is negative and r9 positive
        issue(encode_r(FN_SLT, 5'd17, 5'd8, 5'd9));
        issue(encode_r(FN_SLT, 5'd18, 5'd9, 5'd8));
        report_test("alu");
    endtask

    task automatic back_to_back_issue();
        for (int i = 0; i < 8; i++) begin
            issue(encode_i(OP_ADDIU, 5'(20 + i), 5'd0, rand_imm(1'($urandom))));
        end
        idle(2);
        issue(encode_i(OP_ADDIU, 5'd28, 5'd27, rand_imm(1'b0)));
        report_test("pipelining");
    endtask

    task automatic store_then_load();
        issue(encode_i(OP_ADDIU, 5'd1, 5'd0, {8'h00, 6'($urandom), 2'b00}));
        issue(encode_i(OP_ADDIU, 5'd2, 5'd0, rand_imm(1'($urandom))));
        idle(2);
        issue(encode_i(OP_SW, 5'd2, 5'd1, 16'h0000));
        issue(encode_i(OP_LW, 5'd3, 5'd1, 16'h0000));
        report_test("memory");
    endtask

    task automatic ignored_writes();
        issue(encode_i(OP_ADDIU, 5'd0, 5'd0, rand_imm(1'b0)));
        issue(encode_r(FN_ADDU, 5'd0, 5'd1, 5'd2));
        // unknown opcode with a nonzero rt field
        issue({6'h3f, 5'($urandom), 5'd6, 16'($urandom)});
        // funct 0 is not in the subset
        issue(encode_r(6'h00, 5'd5, 5'd1, 5'd2));
        issue(encode_r(FN_OR, 5'd9, 5'd0, 5'd0));
        report_test("noop");
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        check_count = 0;
        error_count = 0;
        test_base   = 0;
        for (int i = 0; i < 3; i++) begin
            exp_valid[i] = 1'b0;
            exp_reg[i]   = '0;
            exp_data[i]  = '0;
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        void'($urandom(29366));
        reset_sequence();
        immediate_ops();
        register_alu_ops();
        back_to_back_issue();
        store_then_load();
        ignored_writes();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- all.f
hdl/mips_pkg.sv
hdl/mips_stage_if.sv
hdl/register_file.sv
hdl/instruction_decode.sv
hdl/instruction_execute.sv
hdl/memory_writeback.sv
hdl/mips_pipeline_top.sv
tb/mips_pipeline_checker.sv
tb/mips_pipeline_tb.sv

//--- Makefile
# Verilator build and run for the MIPS pipeline testbench

VERILATOR ?= verilator
TOP       ?= mips_pipeline_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hdl/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
